// File: chip8_pkg.sv
// ************************************************
// CHIP-8 shared definitions: host address map,
// writedata field positions, sizes and state codes
// ************************************************
package chip8_pkg;

    // Bus widths
    localparam int ADDR_W = 18;
    localparam int DATA_W = 32;

    // Host address map
    localparam logic [ADDR_W-1:0] REG_BASE   = 18'h00;
    localparam logic [ADDR_W-1:0] REG_LAST   = 18'h0F;
    localparam logic [ADDR_W-1:0] ADDR_I     = 18'h10;
    localparam logic [ADDR_W-1:0] ADDR_SOUND = 18'h11;
    localparam logic [ADDR_W-1:0] ADDR_DELAY = 18'h12;
    localparam logic [ADDR_W-1:0] ADDR_PC    = 18'h14;
    localparam logic [ADDR_W-1:0] ADDR_KEY   = 18'h15;
    localparam logic [ADDR_W-1:0] ADDR_STATE = 18'h16;
    localparam logic [ADDR_W-1:0] ADDR_FB    = 18'h17;
    localparam logic [ADDR_W-1:0] ADDR_MEM   = 18'h19;

    localparam logic [DATA_W-1:0] UNMAPPED_VALUE = 32'h65;

    // Sizes
    localparam int MEM_AW = 12;
    localparam int REG_AW = 4;
    localparam int FB_XW  = 6;
    localparam int FB_YW  = 5;
    localparam int I_W    = 16;
    localparam int PC_W   = 12;
    localparam int KEY_W  = 4;

    localparam logic [PC_W-1:0] PC_RESET = 12'h200;
    localparam int unsigned TICK_DIV_CYCLES = 833333;

    // Field positions in writedata
    localparam int MEM_DATA_LSB    = 0;
    localparam int MEM_ADDR_LSB    = 8;
    localparam int MEM_WE_BIT      = 20;
    localparam int MEM_RD_ADDR_LSB = 12;
    localparam int FB_Y_LSB        = 0;
    localparam int FB_X_LSB        = 5;
    localparam int FB_PIX_BIT      = 11;
    localparam int FB_WE_BIT       = 12;
    localparam int KEY_LSB         = 0;
    localparam int KEY_PRESSED_BIT = 4;

    // Timer slots in the timer bank
    localparam int TMR_DELAY = 0;
    localparam int TMR_SOUND = 1;

    typedef logic [7:0] byte_t;
    typedef logic       pixel_t;

    typedef enum logic [1:0] {
        RUNNING      = 2'd0,
        LOADING_ROM  = 2'd1,
        LOADING_FONT = 2'd2,
        PAUSED       = 2'd3
    } chip8_state_t;

endpackage

// File: ram_if.sv
// ************************************************
// Single storage access port, generic in word type
// ************************************************
interface ram_if #(
    parameter type word_t = logic [7:0],
    parameter int  addr_w = 12
) ();

    logic [addr_w-1:0] addr;
    logic              we;
    word_t             wdata;
    // Data for the address of the previous cycle
    word_t             rdata;

    modport host (output addr, output we, output wdata, input rdata);
    modport mem  (input addr, input we, input wdata, output rdata);

endinterface

// File: timer_if.sv
// ************************************************
// Timer load pulses and timer readback
// ************************************************
interface timer_if import chip8_pkg::*; ();

    logic  delay_we;
    logic  sound_we;
    byte_t load_value;
    byte_t delay_value;
    byte_t sound_value;

    modport host (
        output delay_we,
        output sound_we,
        output load_value,
        input  delay_value,
        input  sound_value
    );

    modport timer (
        input  delay_we,
        input  sound_we,
        input  load_value,
        output delay_value,
        output sound_value
    );

endinterface

// File: chip8_ram.sv
// ************************************************
// Single-port RAM, synchronous write, registered
// read, generic in word type and depth
// ************************************************
module chip8_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 256
) (
    input logic clk,
    ram_if.mem  bus
);

    word_t mem [depth];

    // Read returns the old word on a write to the same address
    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
        bus.rdata <= mem[bus.addr];
    end

endmodule

// File: chip8_timer_bank.sv
// ************************************************
// Delay and sound timers on a 60 Hz tick, with the
// registered sound enable
// ************************************************
module chip8_timer_bank import chip8_pkg::*; #(
    parameter int unsigned tick_div = TICK_DIV_CYCLES
) (
    input  logic    clk,
    input  logic    cpu_fbreset,
    input  logic    running,
    timer_if.timer  tmr,
    output logic    sound_on
);

    logic [$clog2(tick_div + 1)-1:0] div_cnt;
    logic                            tick;
    logic [1:0]                      load;
    byte_t                           count [2];

    // Free-running divider, so the tick phase floats against loads
    assign tick = (div_cnt == $bits(div_cnt)'(tick_div - 1));

    assign load[TMR_DELAY] = tmr.delay_we;
    assign load[TMR_SOUND] = tmr.sound_we;

    assign tmr.delay_value = count[TMR_DELAY];
    assign tmr.sound_value = count[TMR_SOUND];

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            div_cnt  <= '0;
            count[0] <= '0;
            count[1] <= '0;
            sound_on <= 1'b0;
        end else begin
            if (tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            // Load wins over a tick in the same cycle
            for (int t = 0; t < 2; t++) begin
                if (load[t]) begin
                    count[t] <= tmr.load_value;
                end else if (tick && count[t] != '0) begin
                    count[t] <= count[t] - 1'b1;
                end
            end

            sound_on <= running && (count[TMR_SOUND] != '0);
        end
    end

endmodule

// File: chip8_host_regs.sv
// ************************************************
// Host address decoder: holds I, pc, key and state,
// drives storage and timer pulses, forms data_out
// ************************************************
module chip8_host_regs import chip8_pkg::*; (
    input  logic              clk,
    input  logic              cpu_fbreset,
    input  logic              chipselect,
    input  logic              write,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] writedata,
    output logic [DATA_W-1:0] data_out,
    output logic              running,
    ram_if.host               mem_bus,
    ram_if.host               reg_bus,
    ram_if.host               fb_bus,
    timer_if.host             tmr
);

    typedef enum logic [3:0] {
        SRC_VREG, SRC_I, SRC_SOUND, SRC_DELAY, SRC_PC,
        SRC_KEY, SRC_STATE, SRC_FB, SRC_MEM, SRC_NONE
    } src_t;

    logic [I_W-1:0]         i_reg;
    logic [PC_W-1:0]        pc;
    logic [KEY_W-1:0]       key;
    logic                   key_pressed;
    chip8_state_t           state;
    logic [MEM_AW-1:0]      mem_loc;
    logic [FB_XW+FB_YW-1:0] fb_loc;

    src_t              src_dec;
    src_t              src_q;
    logic              pend_q;
    logic              pend_ram_q;
    logic [DATA_W-1:0] reg_word;
    logic [DATA_W-1:0] ram_word;

    assign running      = (state == RUNNING);
    assign mem_bus.addr = mem_loc;
    assign fb_bus.addr  = fb_loc;

    always_comb begin
        src_dec = SRC_NONE;
        case (address)
            ADDR_I:     src_dec = SRC_I;
            ADDR_SOUND: src_dec = SRC_SOUND;
            ADDR_DELAY: src_dec = SRC_DELAY;
            ADDR_PC:    src_dec = SRC_PC;
            ADDR_KEY:   src_dec = SRC_KEY;
            ADDR_STATE: src_dec = SRC_STATE;
            ADDR_FB:    src_dec = SRC_FB;
            ADDR_MEM:   src_dec = SRC_MEM;
            default: begin
                if (address inside {[REG_BASE:REG_LAST]}) begin
                    src_dec = SRC_VREG;
                end
            end
        endcase
    end

    // Read value for sources held here
    always_comb begin
        reg_word = '0;
        case (src_q)
            SRC_I:     reg_word = DATA_W'(i_reg);
            SRC_SOUND: reg_word = DATA_W'(tmr.sound_value);
            SRC_DELAY: reg_word = DATA_W'(tmr.delay_value);
            SRC_PC:    reg_word = DATA_W'(pc);
            SRC_KEY: begin
                reg_word[KEY_LSB +: KEY_W]  = key;
                reg_word[KEY_PRESSED_BIT]   = key_pressed;
            end
            SRC_STATE: reg_word = DATA_W'(state);
            default:   reg_word = UNMAPPED_VALUE;
        endcase
    end

    // Read value for RAM-backed sources
    always_comb begin
        ram_word = '0;
        case (src_q)
            SRC_MEM: begin
                ram_word[MEM_RD_ADDR_LSB +: MEM_AW]      = mem_loc;
                ram_word[MEM_DATA_LSB +: $bits(byte_t)] = mem_bus.rdata;
            end
            SRC_FB:  ram_word[0] = fb_bus.rdata;
            default: ram_word[0 +: $bits(byte_t)] = reg_bus.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            i_reg        <= '0;
            pc           <= PC_RESET;
            key          <= '0;
            key_pressed  <= 1'b0;
            state        <= PAUSED;
            mem_loc      <= '0;
            fb_loc       <= '0;
            src_q        <= SRC_NONE;
            pend_q       <= 1'b0;
            pend_ram_q   <= 1'b0;
            data_out     <= '0;
            mem_bus.we   <= 1'b0;
            reg_bus.we   <= 1'b0;
            fb_bus.we    <= 1'b0;
            tmr.delay_we <= 1'b0;
            tmr.sound_we <= 1'b0;
        end else begin
            // Pulses last a single cycle
            mem_bus.we   <= 1'b0;
            reg_bus.we   <= 1'b0;
            fb_bus.we    <= 1'b0;
            tmr.delay_we <= 1'b0;
            tmr.sound_we <= 1'b0;
            pend_q       <= 1'b0;
            pend_ram_q   <= 1'b0;

            if (chipselect) begin
                src_q  <= src_dec;
                pend_q <= !write;
                if (write) begin
                    case (src_dec)
                        SRC_VREG:  reg_bus.we <= 1'b1;
                        SRC_I:     i_reg <= writedata[I_W-1:0];
                        SRC_SOUND: tmr.sound_we <= 1'b1;
                        SRC_DELAY: tmr.delay_we <= 1'b1;
                        SRC_PC:    pc <= writedata[PC_W-1:0];
                        SRC_KEY: begin
                            key         <= writedata[KEY_LSB +: KEY_W];
                            key_pressed <= writedata[KEY_PRESSED_BIT];
                        end
                        SRC_STATE: begin
                            state <= chip8_state_t'(writedata[$bits(chip8_state_t)-1:0]);
                        end
                        SRC_FB: begin
                            fb_loc    <= {writedata[FB_X_LSB +: FB_XW],
                                          writedata[FB_Y_LSB +: FB_YW]};
                            fb_bus.we <= writedata[FB_WE_BIT];
                        end
                        SRC_MEM: begin
                            mem_loc    <= writedata[MEM_ADDR_LSB +: MEM_AW];
                            mem_bus.we <= writedata[MEM_WE_BIT];
                        end
                        default: ;
                    endcase
                end
            end

            // RAM sources need one more cycle for rdata
            if (pend_q) begin
                if (src_q inside {SRC_VREG, SRC_MEM, SRC_FB}) begin
                    pend_ram_q <= 1'b1;
                end else begin
                    data_out <= reg_word;
                end
            end

            if (pend_ram_q) begin
                data_out <= ram_word;
            end
        end
    end

    // Write data and V register address
    always_ff @(posedge clk) begin
        if (chipselect) begin
            reg_bus.wdata  <= writedata[7:0];
            mem_bus.wdata  <= writedata[MEM_DATA_LSB +: $bits(byte_t)];
            fb_bus.wdata   <= writedata[FB_PIX_BIT];
            tmr.load_value <= writedata[7:0];
            if (src_dec == SRC_VREG) begin
                reg_bus.addr <= address[REG_AW-1:0];
            end
        end
    end

endmodule

// File: chip8_top.sv
// ************************************************
// CHIP-8 host register window: decoder, memory,
// V registers, framebuffer and timers
// ************************************************
module chip8_top import chip8_pkg::*; #(
    parameter int unsigned tick_div = TICK_DIV_CYCLES
) (
    input  logic              clk,
    input  logic              cpu_fbreset,
    input  logic              chipselect,
    input  logic              write,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] writedata,
    output logic [DATA_W-1:0] data_out,
    output logic              sound_on
);

    logic running;

    ram_if #(.word_t(byte_t),  .addr_w(MEM_AW))        mem_bus ();
    ram_if #(.word_t(byte_t),  .addr_w(REG_AW))        reg_bus ();
    // Pixel address is {x, y}
    ram_if #(.word_t(pixel_t), .addr_w(FB_XW + FB_YW)) fb_bus ();
    timer_if                                           tmr ();

    chip8_host_regs u_host (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .data_out    (data_out),
        .running     (running),
        .mem_bus     (mem_bus),
        .reg_bus     (reg_bus),
        .fb_bus      (fb_bus),
        .tmr         (tmr)
    );

    chip8_ram #(
        .word_t (byte_t),
        .depth  (1 << MEM_AW)
    ) u_mem (
        .clk (clk),
        .bus (mem_bus)
    );

    chip8_ram #(
        .word_t (byte_t),
        .depth  (1 << REG_AW)
    ) u_regs (
        .clk (clk),
        .bus (reg_bus)
    );

    chip8_ram #(
        .word_t (pixel_t),
        .depth  (1 << (FB_XW + FB_YW))
    ) u_fb (
        .clk (clk),
        .bus (fb_bus)
    );

    chip8_timer_bank #(
        .tick_div (tick_div)
    ) u_timers (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .running     (running),
        .tmr         (tmr),
        .sound_on    (sound_on)
    );

endmodule

// File: tb_chip8_top.sv
// ************************************************
// Testbench for the CHIP-8 host register window
// ************************************************
module tb_chip8_top import chip8_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TICK = 20;
    // Full run is about a thousand cycles
    localparam int MAX_CYCLES = 20000;

    logic              clk;
    logic              cpu_fbreset;
    logic              chipselect;
    logic              write;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] writedata;
    logic [DATA_W-1:0] data_out;
    logic              sound_on;

    integer seed;
    int     cycles = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     test_fails = 0;

    logic [7:0]        vreg_model [16];
    logic [7:0]        mem_model [4096];
    logic [MEM_AW-1:0] mem_addrs [20];
    logic              pix_model [2048];
    logic [10:0]       pix_locs [24];

    chip8_top #(.tick_div(TICK)) u_dut (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .data_out    (data_out),
        .sound_on    (sound_on)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One strobe, then wait out the slowest read path
    task automatic access(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= wr;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        access(1'b1, addr, data);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        access(1'b0, addr, '0);
        data = data_out;
    endtask

    task automatic check_eq(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
        assert (act === exp) pass_count++;
        else begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            fail_count++;
            test_fails++;
        end
    endtask

    // Either of two values is allowed
    task automatic check_range(input string name, input logic [DATA_W-1:0] lo,
                               input logic [DATA_W-1:0] hi, input logic [DATA_W-1:0] act);
        assert (act === lo || act === hi) pass_count++;
        else begin
            $display("FAIL %s: expected 0x%08h or 0x%08h, actual 0x%08h", name, lo, hi, act);
            fail_count++;
            test_fails++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: done, %0d failed check(s)", name, test_fails);
        test_fails = 0;
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] rnd;
        logic [ADDR_W-1:0] ua;
        logic [MEM_AW-1:0] ma;
        logic [10:0]       loc;
        logic              pv;
        int                lo;
        int                hi;

        seed        = 32'h6999db46;
        clk         = 1'b0;
        cpu_fbreset = 1'b1;
        chipselect  = 1'b0;
        write       = 1'b0;
        address     = '0;
        writedata   = '0;
        repeat (2) @(posedge clk);
        cpu_fbreset <= 1'b0;
        @(negedge clk);

        check_eq("sound_on", 32'd0, DATA_W'(sound_on));
        read_reg(ADDR_STATE, rd);
        check_eq("data_out state", 32'd3, rd);
        read_reg(ADDR_PC, rd);
        check_eq("data_out pc", 32'h200, rd);
        read_reg(ADDR_I, rd);
        check_eq("data_out I", 32'd0, rd);
        finish_test("Test 1 reset values");

        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            vreg_model[i] = rnd[7:0];
            write_reg(ADDR_W'(i), rnd);
        end
        for (int i = 0; i < 16; i++) begin
            read_reg(ADDR_W'(i), rd);
            check_eq($sformatf("data_out V%0d", i), DATA_W'(vreg_model[i]), rd);
        end
        finish_test("Test 2 V registers");

        rnd = $random(seed);
        write_reg(ADDR_I, rnd);
        read_reg(ADDR_I, rd);
        check_eq("data_out I", rnd & 32'hFFFF, rd);
        rnd = $random(seed);
        write_reg(ADDR_PC, rnd);
        read_reg(ADDR_PC, rd);
        check_eq("data_out pc", rnd & 32'hFFF, rd);
        rnd = $random(seed);
        write_reg(ADDR_KEY, rnd);
        read_reg(ADDR_KEY, rd);
        check_eq("data_out key", rnd & 32'h1F, rd);
        rnd = $random(seed);
        write_reg(ADDR_STATE, rnd);
        read_reg(ADDR_STATE, rd);
        check_eq("data_out state", rnd & 32'h3, rd);
        read_reg(18'h13, rd);
        check_eq("data_out addr 0x13", 32'h65, rd);
        read_reg(18'h18, rd);
        check_eq("data_out addr 0x18", 32'h65, rd);
        rnd = $random(seed);
        ua  = ADDR_W'(32'h1A + (rnd % 32'd262118));
        read_reg(ua, rd);
        check_eq($sformatf("data_out addr 0x%05h", ua), 32'h65, rd);
        finish_test("Test 3 decoder registers");

        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            ma  = rnd[19:8];
            mem_addrs[i]  = ma;
            mem_model[ma] = rnd[7:0];
            write_reg(ADDR_MEM, (32'd1 << 20) | (DATA_W'(ma) << 8) | DATA_W'(rnd[7:0]));
        end
        for (int i = 0; i < 20; i++) begin
            ma = mem_addrs[i];
            write_reg(ADDR_MEM, DATA_W'(ma) << 8);
            read_reg(ADDR_MEM, rd);
            check_eq($sformatf("data_out mem 0x%03h", ma),
                     (DATA_W'(ma) << 12) | DATA_W'(mem_model[ma]), rd);
        end
        finish_test("Test 4 memory");

        // First half sets pixels, second half clears some of them
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            loc = rnd[10:0];
            pv  = (i < 12) ? 1'b1 : rnd[11];
            if (i >= 12 && i % 2 == 0) begin
                loc = pix_locs[i - 12];
                pv  = 1'b0;
            end
            pix_locs[i]    = loc;
            pix_model[loc] = pv;
            write_reg(ADDR_FB, (32'd1 << 12) | (DATA_W'(pv) << 11) | DATA_W'(loc));
        end
        for (int i = 0; i < 24; i++) begin
            loc = pix_locs[i];
            write_reg(ADDR_FB, DATA_W'(loc));
            read_reg(ADDR_FB, rd);
            check_eq($sformatf("data_out pixel x%0d y%0d", loc[10:5], loc[4:0]),
                     DATA_W'(pix_model[loc]), rd);
        end
        finish_test("Test 5 framebuffer");

        write_reg(ADDR_STATE, DATA_W'(RUNNING));
        write_reg(ADDR_SOUND, 32'd5);
        write_reg(ADDR_DELAY, 32'd8);
        // Each pass is one tick long, so k or k+1 ticks have gone by
        for (int k = 0; k <= 10; k++) begin
            read_reg(ADDR_DELAY, rd);
            hi = (8 - k > 0) ? 8 - k : 0;
            lo = (7 - k > 0) ? 7 - k : 0;
            check_range($sformatf("data_out delay k=%0d", k), DATA_W'(lo), DATA_W'(hi), rd);
            if (k <= 3) begin
                check_eq($sformatf("sound_on k=%0d", k), 32'd1, DATA_W'(sound_on));
            end else if (k >= 5) begin
                check_eq($sformatf("sound_on k=%0d", k), 32'd0, DATA_W'(sound_on));
            end
            repeat (15) @(posedge clk);
        end
        read_reg(ADDR_DELAY, rd);
        check_eq("data_out delay", 32'd0, rd);
        read_reg(ADDR_SOUND, rd);
        check_eq("data_out sound", 32'd0, rd);
        check_eq("sound_on", 32'd0, DATA_W'(sound_on));

        write_reg(ADDR_STATE, DATA_W'(PAUSED));
        write_reg(ADDR_SOUND, 32'd5);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_eq("sound_on paused", 32'd0, DATA_W'(sound_on));
        read_reg(ADDR_SOUND, rd);
        check_range("data_out sound paused", 32'd4, 32'd5, rd);
        finish_test("Test 6 timers and sound");

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
chip8_pkg.sv
ram_if.sv
timer_if.sv
chip8_ram.sv
chip8_timer_bank.sv
chip8_host_regs.sv
chip8_top.sv
tb_chip8_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_chip8_top \
		-f verilog.f -o sim_chip8
	./obj_dir/sim_chip8 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
